//--- axi_sram_top.f
rtl/axi_pkg.sv
rtl/sram_pkg.sv
rtl/sram_array.sv
rtl/axi_sram_write_ctrl.sv
rtl/axi_sram_read_ctrl.sv
rtl/axi_sram_top.sv
bench/axi_sram_tb.sv

//--- bench/axi_sram_cases.txt
# W <byte addr> <write data> <strobe> <expected resp>   resp 0 is OKAY, 2 is SLVERR
# R <byte addr> <expected data> <expected resp>         all values in hex
W 00000000 11223344 f 0
R 00000000 11223344 0
W 00000004 deadbeef f 0
W 00000008 cafef00d f 0
R 00000004 deadbeef 0
R 00000008 cafef00d 0
W 000003fc 0badc0de f 0
R 000003fc 0badc0de 0
W 00000010 aabbccdd f 0
W 00000010 00000011 1 0
R 00000010 aabbcc11 0
W 00000010 00002200 2 0
W 00000010 00330000 4 0
W 00000010 44000000 8 0
R 00000010 44332211 0
W 00000014 12345678 f 0
W 00000014 ffffffff 5 0
R 00000014 12ff56ff 0
W 00000014 a5a5a5a5 a 0
R 00000014 a5ffa5ff 0
W 00000018 01020304 f 0
W 00000018 ffffffff 0 0
R 00000018 01020304 0
W 00000404 00000000 f 2
R 00000004 deadbeef 0
R 00000404 00000000 2
W 80000000 ffffffff f 2
R 00000000 11223344 0
R 00000400 00000000 2
W 000007fc 55555555 f 2
R 000003fc 0badc0de 0
W 0000002b 0f0f0f0f f 0
R 00000028 0f0f0f0f 0
R 00000009 cafef00d 0
W 00000000 a1b2c3d4 f 0
R 00000003 a1b2c3d4 0

//--- bench/axi_sram_tb.sv
`timescale 1ns/1ps

module axi_sram_tb;
    import axi_pkg::*;

    localparam string CASES_FILE      = "bench/axi_sram_cases.txt";
    localparam int    RESET_CYCLES    = 16;
    localparam int    CYCLES_PER_CASE = 30;
    localparam int    CH_AW = 0;
    localparam int    CH_W  = 1;
    localparam int    CH_B  = 2;
    localparam int    CH_AR = 3;
    localparam int    CH_R  = 4;

    logic                  aclk = 1'b0;
    logic                  areset_n;
    logic                  axi_aw_valid_i;
    logic [AXI_ADDR_W-1:0] axi_aw_addr_i;
    logic                  axi_aw_ready_o;
    logic                  axi_w_valid_i;
    logic [AXI_DATA_W-1:0] axi_w_data_i;
    logic [AXI_STRB_W-1:0] axi_w_strb_i;
    logic                  axi_w_ready_o;
    logic                  axi_b_ready_i;
    logic                  axi_b_valid_o;
    axi_resp_e             axi_b_resp_o;
    logic                  axi_ar_valid_i;
    logic [AXI_ADDR_W-1:0] axi_ar_addr_i;
    logic                  axi_ar_ready_o;
    logic                  axi_r_ready_i;
    logic                  axi_r_valid_o;
    logic [AXI_DATA_W-1:0] axi_r_data_o;
    axi_resp_e             axi_r_resp_o;

    // one entry per line of the cases file
    logic [7:0]            kind_q[$];
    logic [AXI_ADDR_W-1:0] addr_q[$];
    logic [AXI_DATA_W-1:0] data_q[$];
    logic [AXI_STRB_W-1:0] strb_q[$];
    logic [AXI_RESP_W-1:0] resp_q[$];

    integer     seed = 32'h453e_2cce;
    int         fd;
    int         errors = 0;
    int         checks = 0;
    int         mon_errors = 0;
    int         mon_checks = 0;
    int         cycles = 0;
    int         timeout_limit = 0;
    logic       started = 1'b0;  // set when the first request is driven
    logic [4:0] flags;
    logic [4:0] prev_flags = '0;

    axi_sram_top axi_sram_top_inst (.*);

    always #5 aclk = ~aclk;

    //////////////////////////////////////////////////////////////////////
    // handshake helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic channel_flag(input int ch);
        case (ch)
            CH_AW:   return axi_aw_ready_o;
            CH_W:    return axi_w_ready_o;
            CH_B:    return axi_b_valid_o;
            CH_AR:   return axi_ar_ready_o;
            default: return axi_r_valid_o;
        endcase
    endfunction

    // called right after the edge that drove the request, so the answer is due on the 2nd negedge
    task automatic await_flag(input int ch, input string name);
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen) begin
            @(negedge aclk);
            edges++;
            seen = channel_flag(ch);
        end
        checks++;
        assert (edges == 2) else begin
            $display("[ERROR] %0t: %s came %0d negedges after the request, expected 2",
                     $time, name, edges);
            errors++;
        end
    endtask

    task automatic master_delay();
        int delay;
        delay = $unsigned($random(seed)) % 6;
        repeat (delay) @(posedge aclk);
    endtask

    task automatic write_case(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data,
                              input logic [AXI_STRB_W-1:0] strb, input axi_resp_e exp_resp);
        axi_aw_valid_i <= 1'b1;
        axi_aw_addr_i  <= addr;
        await_flag(CH_AW, "aw_ready");
        @(posedge aclk);
        axi_aw_valid_i <= 1'b0;
        axi_w_valid_i  <= 1'b1;
        axi_w_data_i   <= data;
        axi_w_strb_i   <= strb;
        await_flag(CH_W, "w_ready");
        @(posedge aclk);
        axi_w_valid_i <= 1'b0;
        master_delay();
        axi_b_ready_i <= 1'b1;
        await_flag(CH_B, "b_valid");
        checks++;
        assert (axi_b_resp_o == exp_resp) else begin
            $display("[ERROR] %0t: write to 0x%08h answered resp %0d, expected %0d",
                     $time, addr, axi_b_resp_o, exp_resp);
            errors++;
        end
        @(posedge aclk);
        axi_b_ready_i <= 1'b0;
    endtask

    task automatic read_case(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] exp_data,
                             input axi_resp_e exp_resp);
        axi_ar_valid_i <= 1'b1;
        axi_ar_addr_i  <= addr;
        await_flag(CH_AR, "ar_ready");
        @(posedge aclk);
        axi_ar_valid_i <= 1'b0;
        master_delay();
        axi_r_ready_i <= 1'b1;
        await_flag(CH_R, "r_valid");
        checks += 2;
        assert (axi_r_data_o == exp_data) else begin
            $display("[ERROR] %0t: read of 0x%08h returned 0x%08h, expected 0x%08h",
                     $time, addr, axi_r_data_o, exp_data);
            errors++;
        end
        assert (axi_r_resp_o == exp_resp) else begin
            $display("[ERROR] %0t: read of 0x%08h answered resp %0d, expected %0d",
                     $time, addr, axi_r_resp_o, exp_resp);
            errors++;
        end
        @(posedge aclk);
        axi_r_ready_i <= 1'b0;
    endtask

    task automatic read_cases();
        int                    code;
        int                    skipped;
        logic [7:0]            kind;
        logic [8*128-1:0]      rest_of_line;
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic [AXI_RESP_W-1:0] resp;
        code = $fscanf(fd, "%s", kind);
        while (code == 1) begin
            strb = '0;
            if (kind == "W") begin
                skipped = $fscanf(fd, "%h %h %h %h", addr, data, strb, resp);
                if (skipped != 4) begin
                    $display("a write line in the cases file has missing or bad fields");
                    errors++;
                end
            end else if (kind == "R") begin
                skipped = $fscanf(fd, "%h %h %h", addr, data, resp);
                if (skipped != 3) begin
                    $display("a read line in the cases file has missing or bad fields");
                    errors++;
                end
            end else begin
                if (kind != "#") begin
                    $display("unknown line type in the cases file, line skipped");
                    errors++;
                end
                skipped = $fgets(rest_of_line, fd);
            end
            if (kind == "W" || kind == "R") begin
                kind_q.push_back(kind);
                addr_q.push_back(addr);
                data_q.push_back(data);
                strb_q.push_back(strb);
                resp_q.push_back(resp);
            end
            code = $fscanf(fd, "%s", kind);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////////////////////////

    always @(negedge aclk) begin
        flags = {axi_aw_ready_o, axi_w_ready_o, axi_b_valid_o, axi_ar_ready_o, axi_r_valid_o};
        mon_checks++;
        if (!areset_n || !started) begin
            assert (flags == '0) else begin
                $display("[ERROR] %0t: ready or valid high before any request (%b)", $time, flags);
                mon_errors++;
            end
        end
        assert ((flags & prev_flags) == '0) else begin
            $display("[ERROR] %0t: ready or valid held longer than one cycle (%b)", $time, flags);
            mon_errors++;
        end
        prev_flags = flags;
    end

    always @(posedge aclk) begin
        cycles++;
        if (timeout_limit > 0 && cycles > timeout_limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering a handshake", cycles);
            $display("summary: %0d checks, %0d errors", checks + mon_checks, errors + mon_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        areset_n       <= 1'b0;
        axi_aw_valid_i <= 1'b0;
        axi_aw_addr_i  <= '0;
        axi_w_valid_i  <= 1'b0;
        axi_w_data_i   <= '0;
        axi_w_strb_i   <= '0;
        axi_b_ready_i  <= 1'b0;
        axi_ar_valid_i <= 1'b0;
        axi_ar_addr_i  <= '0;
        axi_r_ready_i  <= 1'b0;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("could not open the cases file %s", CASES_FILE);
            $display("TEST FAILED");
            $finish;
        end else begin
            read_cases();
            $fclose(fd);
            if (kind_q.size() == 0) begin
                $display("the cases file holds no transactions");
                errors++;
            end
            timeout_limit = RESET_CYCLES + CYCLES_PER_CASE * kind_q.size();
            repeat (RESET_CYCLES) @(posedge aclk);
            areset_n <= 1'b1;
            repeat (2) @(posedge aclk);
            started = 1'b1;
            for (int i = 0; i < kind_q.size(); i++) begin
                if (kind_q[i] == "W") begin
                    write_case(addr_q[i], data_q[i], strb_q[i], axi_resp_e'(resp_q[i]));
                end else begin
                    read_case(addr_q[i], data_q[i], axi_resp_e'(resp_q[i]));
                end
            end
            repeat (3) @(posedge aclk);
            $display("summary: %0d checks, %0d errors", checks + mon_checks, errors + mon_errors);
            if (errors + mon_errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

//--- rtl/axi_pkg.sv
//////////////////////////////////////////////////////////////////////
// bus widths shared by every bus-facing block
//////////////////////////////////////////////////////////////////////

package axi_pkg;

    // byte address coming from the core memory port
    localparam int AXI_ADDR_W = 32;

    // one data word per beat, no bursts
    localparam int AXI_DATA_W = 32;

    // one strobe bit per data byte
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    localparam int AXI_RESP_W = 2;

    //////////////////////////////////////////////////////////////////////
    // response codes
    //////////////////////////////////////////////////////////////////////

    // only the two codes this slave can answer with are listed
    typedef enum logic [AXI_RESP_W-1:0] {
        AXI_OKAY   = 2'd0,  // access done
        AXI_SLVERR = 2'd2   // address beyond the array
    } axi_resp_e;

endpackage

//--- rtl/axi_sram_read_ctrl.sv
`timescale 1ns/1ps

module axi_sram_read_ctrl #(
    parameter int MEM_WORDS = 256,
    localparam int IDX_W = $clog2(MEM_WORDS)
) (
    input  logic                            aclk,
    input  logic                            areset_n,
    // read address channel
    input  logic                            axi_ar_valid_i,
    input  logic [axi_pkg::AXI_ADDR_W-1:0]  axi_ar_addr_i,
    output logic                            axi_ar_ready_o,
    // read data channel
    input  logic                            axi_r_ready_i,
    output logic                            axi_r_valid_o,
    output logic [axi_pkg::AXI_DATA_W-1:0]  axi_r_data_o,
    output axi_pkg::axi_resp_e              axi_r_resp_o,
    // array read port
    output logic                            rd_en_o,
    output logic [IDX_W-1:0]                rd_idx_o,
    input  logic [axi_pkg::AXI_DATA_W-1:0]  rd_data_i
);
    import axi_pkg::*;
    import sram_pkg::*;

    sram_r_state_e r_state;
    logic          ar_in_range;
    logic          r_in_range;

    assign ar_in_range = (axi_ar_addr_i[AXI_ADDR_W-1:IDX_W+2] == '0);

    always_ff @(posedge aclk) begin
        if (r_state == R_IDLE && axi_ar_valid_i) begin
            rd_idx_o <= axi_ar_addr_i[IDX_W+1:2];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            r_state        <= R_IDLE;
            r_in_range     <= 1'b0;
            axi_ar_ready_o <= 1'b0;
            axi_r_valid_o  <= 1'b0;
            rd_en_o        <= 1'b0;
        end else begin
            case (r_state)
                R_IDLE: begin
                    if (axi_ar_valid_i) begin
                        r_state        <= R_ADDR;
                        r_in_range     <= ar_in_range;
                        axi_ar_ready_o <= 1'b1;
                        rd_en_o        <= 1'b1;  // array word is registered at the next edge
                    end
                end
                R_ADDR: begin
                    axi_ar_ready_o <= 1'b0;
                    rd_en_o        <= 1'b0;
                    if (axi_r_ready_i) begin
                        r_state       <= R_DATA;
                        axi_r_valid_o <= 1'b1;
                    end
                end
                R_DATA: begin
                    axi_r_valid_o <= 1'b0;
                    r_state       <= R_IDLE;
                end
                default: begin
                    r_state <= R_IDLE;
                end
            endcase
        end
    end

    // array output holds until the next read, so it is stable through R_ADDR
    assign axi_r_data_o = r_in_range ? rd_data_i : '0;
    assign axi_r_resp_o = r_in_range ? AXI_OKAY : AXI_SLVERR;

endmodule

//--- rtl/axi_sram_top.sv
`timescale 1ns/1ps

module axi_sram_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                            aclk,
    input  logic                            areset_n,
    // write address channel
    input  logic                            axi_aw_valid_i,
    input  logic [axi_pkg::AXI_ADDR_W-1:0]  axi_aw_addr_i,
    output logic                            axi_aw_ready_o,
    // write data channel
    input  logic                            axi_w_valid_i,
    input  logic [axi_pkg::AXI_DATA_W-1:0]  axi_w_data_i,
    input  logic [axi_pkg::AXI_STRB_W-1:0]  axi_w_strb_i,
    output logic                            axi_w_ready_o,
    // write response channel
    input  logic                            axi_b_ready_i,
    output logic                            axi_b_valid_o,
    output axi_pkg::axi_resp_e              axi_b_resp_o,
    // read address channel
    input  logic                            axi_ar_valid_i,
    input  logic [axi_pkg::AXI_ADDR_W-1:0]  axi_ar_addr_i,
    output logic                            axi_ar_ready_o,
    // read data channel
    input  logic                            axi_r_ready_i,
    output logic                            axi_r_valid_o,
    output logic [axi_pkg::AXI_DATA_W-1:0]  axi_r_data_o,
    output axi_pkg::axi_resp_e              axi_r_resp_o
);
    import axi_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic                  wr_en;
    logic [IDX_W-1:0]      wr_idx;
    logic [AXI_DATA_W-1:0] wr_data;
    logic [AXI_STRB_W-1:0] wr_strb;
    logic                  rd_en;
    logic [IDX_W-1:0]      rd_idx;
    logic [AXI_DATA_W-1:0] rd_data;

    //////////////////////////////////////////////////////////////////////
    // channel controllers and the array
    //////////////////////////////////////////////////////////////////////

    axi_sram_write_ctrl #(.MEM_WORDS(MEM_WORDS)) axi_sram_write_ctrl_inst (
        .aclk(aclk), .areset_n(areset_n),
        .axi_aw_valid_i(axi_aw_valid_i), .axi_aw_addr_i(axi_aw_addr_i),
        .axi_aw_ready_o(axi_aw_ready_o),
        .axi_w_valid_i(axi_w_valid_i), .axi_w_data_i(axi_w_data_i),
        .axi_w_strb_i(axi_w_strb_i), .axi_w_ready_o(axi_w_ready_o),
        .axi_b_ready_i(axi_b_ready_i), .axi_b_valid_o(axi_b_valid_o),
        .axi_b_resp_o(axi_b_resp_o),
        .wr_en_o(wr_en), .wr_idx_o(wr_idx), .wr_data_o(wr_data), .wr_strb_o(wr_strb)
    );

    axi_sram_read_ctrl #(.MEM_WORDS(MEM_WORDS)) axi_sram_read_ctrl_inst (
        .aclk(aclk), .areset_n(areset_n),
        .axi_ar_valid_i(axi_ar_valid_i), .axi_ar_addr_i(axi_ar_addr_i),
        .axi_ar_ready_o(axi_ar_ready_o),
        .axi_r_ready_i(axi_r_ready_i), .axi_r_valid_o(axi_r_valid_o),
        .axi_r_data_o(axi_r_data_o), .axi_r_resp_o(axi_r_resp_o),
        .rd_en_o(rd_en), .rd_idx_o(rd_idx), .rd_data_i(rd_data)
    );

    sram_array #(.MEM_WORDS(MEM_WORDS)) sram_array_inst (
        .aclk(aclk), .areset_n(areset_n),
        .wr_en_i(wr_en), .wr_idx_i(wr_idx), .wr_data_i(wr_data), .wr_strb_i(wr_strb),
        .rd_en_i(rd_en), .rd_idx_i(rd_idx), .rd_data_o(rd_data)
    );

endmodule

//--- rtl/axi_sram_write_ctrl.sv
`timescale 1ns/1ps

module axi_sram_write_ctrl #(
    parameter int MEM_WORDS = 256,
    localparam int IDX_W = $clog2(MEM_WORDS)
) (
    input  logic                            aclk,
    input  logic                            areset_n,
    // write address channel
    input  logic                            axi_aw_valid_i,
    input  logic [axi_pkg::AXI_ADDR_W-1:0]  axi_aw_addr_i,
    output logic                            axi_aw_ready_o,
    // write data channel
    input  logic                            axi_w_valid_i,
    input  logic [axi_pkg::AXI_DATA_W-1:0]  axi_w_data_i,
    input  logic [axi_pkg::AXI_STRB_W-1:0]  axi_w_strb_i,
    output logic                            axi_w_ready_o,
    // write response channel
    input  logic                            axi_b_ready_i,
    output logic                            axi_b_valid_o,
    output axi_pkg::axi_resp_e              axi_b_resp_o,
    // array write port
    output logic                            wr_en_o,
    output logic [IDX_W-1:0]                wr_idx_o,
    output logic [axi_pkg::AXI_DATA_W-1:0]  wr_data_o,
    output logic [axi_pkg::AXI_STRB_W-1:0]  wr_strb_o
);
    import axi_pkg::*;
    import sram_pkg::*;

    sram_w_state_e w_state;
    logic          aw_in_range;
    logic          w_in_range;

    // MEM_WORDS is a power of two, so the word number fits when the upper bits are clear
    assign aw_in_range = (axi_aw_addr_i[AXI_ADDR_W-1:IDX_W+2] == '0);

    //////////////////////////////////////////////////////////////////////
    // address and data capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (w_state == W_IDLE && axi_aw_valid_i) begin
            wr_idx_o <= axi_aw_addr_i[IDX_W+1:2];  // low two bits are ignored
        end
        if (w_state == W_ADDR && axi_w_valid_i) begin
            wr_data_o <= axi_w_data_i;
            wr_strb_o <= axi_w_strb_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // write FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            w_state        <= W_IDLE;
            w_in_range     <= 1'b0;
            axi_aw_ready_o <= 1'b0;
            axi_w_ready_o  <= 1'b0;
            axi_b_valid_o  <= 1'b0;
            axi_b_resp_o   <= AXI_OKAY;
            wr_en_o        <= 1'b0;
        end else begin
            case (w_state)
                W_IDLE: begin
                    if (axi_aw_valid_i) begin
                        w_state        <= W_ADDR;
                        w_in_range     <= aw_in_range;
                        axi_aw_ready_o <= 1'b1;  // single cycle answer to valid
                    end
                end
                W_ADDR: begin
                    axi_aw_ready_o <= 1'b0;
                    if (axi_w_valid_i) begin
                        w_state       <= W_DATA;
                        axi_w_ready_o <= 1'b1;
                        wr_en_o       <= w_in_range;  // out of range never reaches the array
                    end
                end
                W_DATA: begin
                    axi_w_ready_o <= 1'b0;
                    wr_en_o       <= 1'b0;
                    if (axi_b_ready_i) begin
                        w_state       <= W_RESP;
                        axi_b_valid_o <= 1'b1;
                        axi_b_resp_o  <= w_in_range ? AXI_OKAY : AXI_SLVERR;
                    end
                end
                W_RESP: begin
                    axi_b_valid_o <= 1'b0;
                    w_state       <= W_IDLE;
                end
                default: begin
                    w_state <= W_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/sram_array.sv
`timescale 1ns/1ps

module sram_array #(
    parameter int MEM_WORDS = 256,
    localparam int IDX_W = $clog2(MEM_WORDS)
) (
    input  logic                            aclk,
    input  logic                            areset_n,
    // write port
    input  logic                            wr_en_i,
    input  logic [IDX_W-1:0]                wr_idx_i,
    input  logic [axi_pkg::AXI_DATA_W-1:0]  wr_data_i,
    input  logic [axi_pkg::AXI_STRB_W-1:0]  wr_strb_i,
    // read port
    input  logic                            rd_en_i,
    input  logic [IDX_W-1:0]                rd_idx_i,
    output logic [axi_pkg::AXI_DATA_W-1:0]  rd_data_o
);
    import axi_pkg::*;

    logic [AXI_DATA_W-1:0] mem [MEM_WORDS];

    //////////////////////////////////////////////////////////////////////
    // byte-strobed write
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (wr_en_i) begin
            for (int b = 0; b < AXI_STRB_W; b++) begin
                if (wr_strb_i[b]) begin
                    mem[wr_idx_i][8*b +: 8] <= wr_data_i[8*b +: 8];  // unstrobed bytes keep their value
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered read
    //////////////////////////////////////////////////////////////////////

    // a write to the same word in this cycle is not seen, the old word comes out
    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_idx_i];
        end
    end

endmodule

//--- rtl/sram_pkg.sv
//////////////////////////////////////////////////////////////////////
// controller state encodings
//////////////////////////////////////////////////////////////////////

package sram_pkg;

    // write side walks address, data, then the response pulse
    typedef enum logic [1:0] {
        W_IDLE = 2'd0,  // waiting for a write address
        W_ADDR = 2'd1,  // address taken, waiting for write data
        W_DATA = 2'd2,  // data taken, waiting for the master to be ready
        W_RESP = 2'd3   // response valid for one cycle
    } sram_w_state_e;

    // read side has no separate data strobe from the master
    typedef enum logic [1:0] {
        R_IDLE = 2'd0,  // waiting for a read address
        R_ADDR = 2'd1,  // address taken, array read issued
        R_DATA = 2'd2   // read data valid for one cycle
    } sram_r_state_e;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI SRAM testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/axi_sram_sim

verilator --binary --timing --assert \
    -f axi_sram_top.f \
    --top-module axi_sram_tb \
    --Mdir obj_dir -o axi_sram_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
